/* la_core_pkg.sv */
package la_core_pkg;

    localparam int XLEN       = 32;
    localparam int GPR_AW     = 5;
    localparam int GPR_NUM    = 1 << GPR_AW;
    localparam int DMEM_BYTES = 64;
    localparam int DMEM_AW    = $clog2(DMEM_BYTES);

    // Major opcode, instr[31:22]
    typedef enum logic [9:0] {
        OPC_SLTI   = 10'h008,
        OPC_SLTUI  = 10'h009,
        OPC_ADDI_W = 10'h00A,
        OPC_ANDI   = 10'h00D,
        OPC_ORI    = 10'h00E,
        OPC_XORI   = 10'h00F,
        OPC_LD_B   = 10'h0A0,
        OPC_LD_H   = 10'h0A1,
        OPC_LD_W   = 10'h0A2,
        OPC_ST_B   = 10'h0A4,
        OPC_ST_H   = 10'h0A5,
        OPC_ST_W   = 10'h0A6,
        OPC_LD_BU  = 10'h0A8,
        OPC_LD_HU  = 10'h0A9,
        OPC_PRELD  = 10'h0AB
    } opcode_e;

    typedef enum logic [7:0] {
        ALU_NOP, ALU_ADD, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR,
        ALU_LD_B, ALU_LD_H, ALU_LD_W, ALU_LD_BU, ALU_LD_HU,
        ALU_ST_B, ALU_ST_H, ALU_ST_W
    } alu_op_e;

    // Result class
    typedef enum logic [2:0] {
        SEL_NOP, SEL_LOGIC, SEL_ARITH, SEL_LOAD_STORE
    } alu_sel_e;

    typedef enum logic [1:0] {
        DEC_IDLE, DEC_BUSY, DEC_ACK
    } dec_state_e;

    typedef struct packed {
        logic              valid;   // Recognized opcode
        logic [1:0]        rf_re;   // {rd_src, rj}
        logic [GPR_AW-1:0] rj;
        logic [GPR_AW-1:0] rd_src;  // Store data register
        logic [XLEN-1:0]   imm;     // Already extended
        logic              rf_we;
        logic [GPR_AW-1:0] waddr;
        alu_op_e           aluop;
        alu_sel_e          alusel;
    } dec_info_t;

    typedef struct packed {
        logic              valid;
        logic              illegal;
        logic              rf_we;
        logic [GPR_AW-1:0] waddr;
        logic [XLEN-1:0]   wdata;
    } exe_result_t;

endpackage

/* dec_exe_if.sv */
`timescale 1ns/10ps

interface dec_exe_if;
    import la_core_pkg::*;

    dec_info_t info;   // Held stable until the next accept
    logic      start;  // One cycle, info is fresh

    modport dec (
        output info,
        output start
    );

    modport exe (
        input info,
        input start
    );

endinterface

/* exe_res_if.sv */
`timescale 1ns/10ps

interface exe_res_if;
    import la_core_pkg::*;

    exe_result_t result;
    logic        done;    // One cycle, result is fresh
    logic        retire;  // Back toward the decoder, driven through the result stage port

    modport exe (
        output result,
        output done
    );

    modport res (
        input result,
        input done
    );

endinterface

/* decoder_2ri12.sv */
`timescale 1ns/10ps

module decoder_2ri12 (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        instr_req_i,
    input  logic [31:0] instr_i,
    input  logic        retire_i,
    output logic        instr_ack_o,
    dec_exe_if.dec      dec_o
);
    import la_core_pkg::*;

    dec_state_e        state_q;
    dec_info_t         info_d;
    dec_info_t         info_q;
    logic              start_q;
    logic              accept;
    logic              sext;
    logic [GPR_AW-1:0] rd;
    logic [GPR_AW-1:0] rj;
    logic [11:0]       imm12;
    opcode_e           opc;

    // 2RI12 layout {opcode[10], imm[12], rj[5], rd[5]}
    assign rd    = instr_i[4:0];
    assign rj    = instr_i[9:5];
    assign imm12 = instr_i[21:10];
    assign opc   = opcode_e'(instr_i[31:22]);

    always_comb begin
        info_d        = '0;
        info_d.valid  = 1'b1;
        info_d.rf_re  = 2'b01;
        info_d.rj     = rj;
        info_d.rd_src = rd;
        info_d.rf_we  = 1'b1;
        info_d.waddr  = rd;
        info_d.aluop  = ALU_NOP;
        info_d.alusel = SEL_NOP;
        sext          = 1'b1;

        case (opc)
            OPC_SLTI:   info_d.aluop = ALU_SLT;
            OPC_SLTUI:  info_d.aluop = ALU_SLTU;
            OPC_ADDI_W: info_d.aluop = ALU_ADD;
            OPC_ANDI:   info_d.aluop = ALU_AND;
            OPC_ORI:    info_d.aluop = ALU_OR;
            OPC_XORI:   info_d.aluop = ALU_XOR;
            OPC_LD_B:   info_d.aluop = ALU_LD_B;
            OPC_LD_H:   info_d.aluop = ALU_LD_H;
            OPC_LD_W:   info_d.aluop = ALU_LD_W;
            OPC_LD_BU:  info_d.aluop = ALU_LD_BU;
            OPC_LD_HU:  info_d.aluop = ALU_LD_HU;
            OPC_ST_B:   info_d.aluop = ALU_ST_B;
            OPC_ST_H:   info_d.aluop = ALU_ST_H;
            OPC_ST_W:   info_d.aluop = ALU_ST_W;
            OPC_PRELD:  info_d.aluop = ALU_NOP;
            default:    info_d.valid = 1'b0;
        endcase

        // Class and register usage follow from the operation
        case (info_d.aluop)
            ALU_ADD, ALU_SLT, ALU_SLTU: info_d.alusel = SEL_ARITH;
            ALU_AND, ALU_OR, ALU_XOR: begin
                info_d.alusel = SEL_LOGIC;
                sext          = 1'b0;       // Logic ops take a zero-extended imm
            end
            ALU_ST_B, ALU_ST_H, ALU_ST_W: begin
                info_d.alusel = SEL_LOAD_STORE;
                info_d.rf_re  = 2'b11;      // Base in rj, data in rd
                info_d.rf_we  = 1'b0;
                info_d.waddr  = '0;
            end
            ALU_NOP: begin                  // PRELD or illegal
                info_d.rf_we  = 1'b0;
                info_d.waddr  = '0;
            end
            default: info_d.alusel = SEL_LOAD_STORE;
        endcase

        if (!info_d.valid) begin
            info_d.rf_re = 2'b00;
        end

        info_d.imm = sext ? {{(XLEN-12){imm12[11]}}, imm12} : {{(XLEN-12){1'b0}}, imm12};
    end

    assign accept = (state_q == DEC_IDLE) && instr_req_i;

    // Four-phase handshake
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= DEC_IDLE;
            start_q <= 1'b0;
        end else begin
            start_q <= accept;
            case (state_q)
                DEC_IDLE: if (instr_req_i) state_q <= DEC_BUSY;
                DEC_BUSY: if (retire_i) state_q <= DEC_ACK;
                DEC_ACK:  if (!instr_req_i) state_q <= DEC_IDLE;
                default:  state_q <= DEC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            info_q <= info_d;
        end
    end

    assign instr_ack_o = (state_q == DEC_ACK);
    assign dec_o.info  = info_q;
    assign dec_o.start = start_q;

endmodule

/* gpr_file.sv */
`timescale 1ns/10ps

module gpr_file (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic [la_core_pkg::GPR_AW-1:0] raddr_a_i,
    input  logic [la_core_pkg::GPR_AW-1:0] raddr_b_i,
    input  logic                         we_i,
    input  logic [la_core_pkg::GPR_AW-1:0] waddr_i,
    input  logic [la_core_pkg::XLEN-1:0]   wdata_i,
    output logic [la_core_pkg::XLEN-1:0]   rdata_a_o,
    output logic [la_core_pkg::XLEN-1:0]   rdata_b_o
);
    import la_core_pkg::*;

    logic [XLEN-1:0] regs_q [GPR_NUM];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < GPR_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin  // r0 is never written
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Asynchronous reads
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* alu_lsu_exec.sv */
`timescale 1ns/10ps

module alu_lsu_exec (
    input  logic                           clk,
    input  logic                           rst_n_i,
    output logic [la_core_pkg::GPR_AW-1:0] raddr_a_o,
    output logic [la_core_pkg::GPR_AW-1:0] raddr_b_o,
    input  logic [la_core_pkg::XLEN-1:0]   rdata_a_i,
    input  logic [la_core_pkg::XLEN-1:0]   rdata_b_i,
    dec_exe_if.exe                         dec_i,
    exe_res_if.exe                         res_o
);
    import la_core_pkg::*;

    dec_info_t          info;
    exe_result_t        result_q;
    logic               done_q;
    logic [XLEN-1:0]    op_a;
    logic [XLEN-1:0]    op_b;
    logic [XLEN-1:0]    sum;
    logic [XLEN-1:0]    arith_res;
    logic [XLEN-1:0]    logic_res;
    logic [XLEN-1:0]    load_res;
    logic [XLEN-1:0]    wdata;
    logic [XLEN-1:0]    mem_word;
    logic [7:0]         mem_byte;
    logic [15:0]        mem_half;
    logic [DMEM_AW-1:0] addr;
    logic [7:0]         dmem_q [DMEM_BYTES];

    assign info      = dec_i.info;
    assign raddr_a_o = info.rj;
    assign raddr_b_o = info.rd_src;
    assign op_a      = info.rf_re[0] ? rdata_a_i : '0;
    assign op_b      = info.rf_re[1] ? rdata_b_i : '0;
    assign sum       = op_a + info.imm;

    // Byte address wraps at 64, then aligned to the access size
    always_comb begin
        addr = sum[DMEM_AW-1:0];
        case (info.aluop)
            ALU_LD_H, ALU_LD_HU, ALU_ST_H: addr[0]   = 1'b0;
            ALU_LD_W, ALU_ST_W:            addr[1:0] = 2'b00;
            default: ;
        endcase
    end

    // Little-endian word holding the addressed byte
    assign mem_word = {dmem_q[{addr[DMEM_AW-1:2], 2'd3}], dmem_q[{addr[DMEM_AW-1:2], 2'd2}],
                       dmem_q[{addr[DMEM_AW-1:2], 2'd1}], dmem_q[{addr[DMEM_AW-1:2], 2'd0}]};
    assign mem_byte = mem_word[addr[1:0]*8 +: 8];
    assign mem_half = mem_word[addr[1]*16 +: 16];

    always_comb begin
        case (info.aluop)
            ALU_SLT:  arith_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(info.imm)};
            ALU_SLTU: arith_res = {{(XLEN-1){1'b0}}, op_a < info.imm};
            default:  arith_res = sum;
        endcase

        case (info.aluop)
            ALU_AND: logic_res = op_a & info.imm;
            ALU_OR:  logic_res = op_a | info.imm;
            default: logic_res = op_a ^ info.imm;
        endcase

        case (info.aluop)
            ALU_LD_B:  load_res = {{(XLEN-8){mem_byte[7]}}, mem_byte};
            ALU_LD_BU: load_res = {{(XLEN-8){1'b0}}, mem_byte};
            ALU_LD_H:  load_res = {{(XLEN-16){mem_half[15]}}, mem_half};
            ALU_LD_HU: load_res = {{(XLEN-16){1'b0}}, mem_half};
            ALU_LD_W:  load_res = mem_word;
            default:   load_res = '0;   // Stores write nothing back
        endcase

        case (info.alusel)
            SEL_ARITH:      wdata = arith_res;
            SEL_LOGIC:      wdata = logic_res;
            SEL_LOAD_STORE: wdata = load_res;
            default:        wdata = '0;
        endcase
    end

    // Stores commit in the execute cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_q <= 1'b0;
            for (int i = 0; i < DMEM_BYTES; i++) begin
                dmem_q[i] <= '0;
            end
        end else begin
            done_q <= dec_i.start;
            if (dec_i.start) begin
                case (info.aluop)
                    ALU_ST_B: dmem_q[addr] <= op_b[7:0];
                    ALU_ST_H: begin
                        dmem_q[addr]                   <= op_b[7:0];
                        dmem_q[{addr[DMEM_AW-1:1], 1'b1}] <= op_b[15:8];
                    end
                    ALU_ST_W: begin
                        dmem_q[{addr[DMEM_AW-1:2], 2'd0}] <= op_b[7:0];
                        dmem_q[{addr[DMEM_AW-1:2], 2'd1}] <= op_b[15:8];
                        dmem_q[{addr[DMEM_AW-1:2], 2'd2}] <= op_b[23:16];
                        dmem_q[{addr[DMEM_AW-1:2], 2'd3}] <= op_b[31:24];
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec_i.start) begin
            result_q.valid   <= info.valid;
            result_q.illegal <= ~info.valid;
            result_q.rf_we   <= info.rf_we;
            result_q.waddr   <= info.waddr;
            result_q.wdata   <= wdata;
        end
    end

    assign res_o.result = result_q;
    assign res_o.done   = done_q;

endmodule

/* result_commit.sv */
`timescale 1ns/10ps

module result_commit (
    input  logic                           clk,
    input  logic                           rst_n_i,
    output logic                           rf_we_o,
    output logic [la_core_pkg::GPR_AW-1:0] rf_waddr_o,
    output logic [la_core_pkg::XLEN-1:0]   rf_wdata_o,
    output logic                           retire_o,
    output logic                           wb_valid_o,
    output logic                           wb_illegal_o,
    output logic [la_core_pkg::GPR_AW-1:0] wb_addr_o,
    output logic [la_core_pkg::XLEN-1:0]   wb_data_o,
    exe_res_if.res                         res_i
);
    import la_core_pkg::*;

    exe_result_t res;

    assign res = res_i.result;

    // Register file takes the write on the done edge
    assign rf_we_o    = res_i.done & res.valid & res.rf_we & (res.waddr != '0);
    assign rf_waddr_o = res.waddr;
    assign rf_wdata_o = res.wdata;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            retire_o     <= 1'b0;
            wb_valid_o   <= 1'b0;
            wb_illegal_o <= 1'b0;
            wb_addr_o    <= '0;
            wb_data_o    <= '0;
        end else begin
            retire_o <= res_i.done;
            if (res_i.done) begin    // Held until the next instruction retires
                wb_valid_o   <= res.rf_we;
                wb_illegal_o <= res.illegal;
                wb_addr_o    <= res.rf_we ? res.waddr : '0;
                wb_data_o    <= res.rf_we ? res.wdata : '0;
            end
        end
    end

endmodule

/* la_2ri12_top.sv */
`timescale 1ns/10ps

module la_2ri12_top (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           instr_req_i,
    input  logic [31:0]                    instr_i,
    output logic                           instr_ack_o,
    output logic                           wb_valid_o,
    output logic                           wb_illegal_o,
    output logic [la_core_pkg::GPR_AW-1:0] wb_addr_o,
    output logic [la_core_pkg::XLEN-1:0]   wb_data_o
);
    import la_core_pkg::*;

    logic [GPR_AW-1:0] raddr_a;
    logic [GPR_AW-1:0] raddr_b;
    logic [XLEN-1:0]   rdata_a;
    logic [XLEN-1:0]   rdata_b;
    logic              rf_we;
    logic [GPR_AW-1:0] rf_waddr;
    logic [XLEN-1:0]   rf_wdata;

    dec_exe_if dec_exe ();
    exe_res_if exe_res ();

    decoder_2ri12 u_decoder (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .instr_req_i (instr_req_i),
        .instr_i     (instr_i),
        .retire_i    (exe_res.retire),
        .instr_ack_o (instr_ack_o),
        .dec_o       (dec_exe.dec)
    );

    gpr_file u_gpr (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (raddr_a),
        .raddr_b_i (raddr_b),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b)
    );

    alu_lsu_exec u_exec (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .raddr_a_o (raddr_a),
        .raddr_b_o (raddr_b),
        .rdata_a_i (rdata_a),
        .rdata_b_i (rdata_b),
        .dec_i     (dec_exe.exe),
        .res_o     (exe_res.exe)
    );

    result_commit u_commit (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .rf_we_o      (rf_we),
        .rf_waddr_o   (rf_waddr),
        .rf_wdata_o   (rf_wdata),
        .retire_o     (exe_res.retire),
        .wb_valid_o   (wb_valid_o),
        .wb_illegal_o (wb_illegal_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o),
        .res_i        (exe_res.res)
    );

endmodule

/* tb_la_2ri12.sv */
`timescale 1ns/10ps

module tb_la_2ri12;
    import la_core_pkg::*;

    localparam int NUM_TESTS      = 28;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 10 + 20;

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic        instr_req_i;
    logic [31:0] instr_i;
    logic        instr_ack_o;
    logic        wb_valid_o;
    logic        wb_illegal_o;
    logic [4:0]  wb_addr_o;
    logic [31:0] wb_data_o;

    // One row of stimulus and expected writeback per instruction
    string       tbl_name    [NUM_TESTS];
    logic [31:0] tbl_word    [NUM_TESTS];
    logic        tbl_valid   [NUM_TESTS];
    logic        tbl_illegal [NUM_TESTS];
    logic [4:0]  tbl_addr    [NUM_TESTS];
    logic [31:0] tbl_data    [NUM_TESTS];

    int n_entries = 0;
    int errors    = 0;
    int checks    = 0;
    int cycle_cnt = 0;

    la_2ri12_top dut_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .instr_req_i  (instr_req_i),
        .instr_i      (instr_i),
        .instr_ack_o  (instr_ack_o),
        .wb_valid_o   (wb_valid_o),
        .wb_illegal_o (wb_illegal_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o)
    );

    always #20 clk = ~clk;  // 40 ns period

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("ERROR: handshake did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("Closing: %0d checks, %0d errors", checks, errors);
            $display("Checks failed");
            $finish;
        end
    end

    // 2RI12 word {opcode, imm12, rj, rd}
    function automatic logic [31:0] encode_2ri12(input logic [9:0] opc, input logic [11:0] imm,
                                                 input logic [4:0] rj, input logic [4:0] rd);
        return {opc, imm, rj, rd};
    endfunction

    task automatic add_entry(input string name, input logic [31:0] word, input logic valid,
                             input logic illegal, input logic [4:0] addr,
                             input logic [31:0] data);
        tbl_name[n_entries]    = name;
        tbl_word[n_entries]    = word;
        tbl_valid[n_entries]   = valid;
        tbl_illegal[n_entries] = illegal;
        tbl_addr[n_entries]    = addr;
        tbl_data[n_entries]    = data;
        n_entries++;
    endtask

    task automatic check_val(input string test, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s %s: expected 0x%08h, actual 0x%08h at %0t",
                     test, what, expected, actual, $time);
        end
    endtask

    task automatic build_table;
        // Constants in r1..r13
        add_entry("addi_neg",  encode_2ri12(OPC_ADDI_W, 12'hFFF, 5'd0, 5'd1), 1, 0, 1, 32'hFFFF_FFFF);
        add_entry("ori_zext",  encode_2ri12(OPC_ORI,    12'hFFF, 5'd0, 5'd2), 1, 0, 2, 32'h0000_0FFF);
        add_entry("addi_pos",  encode_2ri12(OPC_ADDI_W, 12'h7FF, 5'd0, 5'd3), 1, 0, 3, 32'h0000_07FF);
        add_entry("xori",      encode_2ri12(OPC_XORI,   12'h0A5, 5'd3, 5'd4), 1, 0, 4, 32'h0000_075A);
        add_entry("andi_zext", encode_2ri12(OPC_ANDI,   12'hAA5, 5'd1, 5'd6), 1, 0, 6, 32'h0000_0AA5);
        add_entry("andi_reg",  encode_2ri12(OPC_ANDI,   12'h0F0, 5'd4, 5'd7), 1, 0, 7, 32'h0000_0050);
        // Signed against unsigned compare
        add_entry("slti_neg",  encode_2ri12(OPC_SLTI,   12'h001, 5'd1, 5'd8), 1, 0, 8, 32'h1);
        add_entry("sltui_neg", encode_2ri12(OPC_SLTUI,  12'h001, 5'd1, 5'd10), 1, 0, 10, 32'h0);
        add_entry("addi_one",  encode_2ri12(OPC_ADDI_W, 12'h001, 5'd0, 5'd9), 1, 0, 9, 32'h1);
        add_entry("slti_pos",  encode_2ri12(OPC_SLTI,   12'hFFF, 5'd9, 5'd11), 1, 0, 11, 32'h0);
        add_entry("sltui_pos", encode_2ri12(OPC_SLTUI,  12'hFFF, 5'd9, 5'd12), 1, 0, 12, 32'h1);
        add_entry("addi_data", encode_2ri12(OPC_ADDI_W, 12'h8F3, 5'd0, 5'd13),
                  1, 0, 13, 32'hFFFF_F8F3);
        // Word store at 8, half at 0x13 aligned to 0x12 and byte at -1 + 0x26
        add_entry("st_w",      encode_2ri12(OPC_ST_W,   12'h008, 5'd0, 5'd13), 0, 0, 0, 32'h0);
        add_entry("st_h",      encode_2ri12(OPC_ST_H,   12'h012, 5'd9, 5'd4), 0, 0, 0, 32'h0);
        add_entry("st_b",      encode_2ri12(OPC_ST_B,   12'h026, 5'd1, 5'd6), 0, 0, 0, 32'h0);
        // Memory now holds F3 F8 FF FF at 8 and 5A 07 at 0x12
        add_entry("ld_w",      encode_2ri12(OPC_LD_W,   12'h008, 5'd0, 5'd15),
                  1, 0, 15, 32'hFFFF_F8F3);
        add_entry("ld_w_wrap", encode_2ri12(OPC_LD_W,   12'h04B, 5'd0, 5'd16),
                  1, 0, 16, 32'hFFFF_F8F3);
        add_entry("ld_h_neg",  encode_2ri12(OPC_LD_H,   12'h008, 5'd0, 5'd17),
                  1, 0, 17, 32'hFFFF_F8F3);
        add_entry("ld_hu",     encode_2ri12(OPC_LD_HU,  12'h009, 5'd0, 5'd18),
                  1, 0, 18, 32'h0000_F8F3);
        add_entry("ld_h_pos",  encode_2ri12(OPC_LD_H,   12'h012, 5'd0, 5'd19),
                  1, 0, 19, 32'h0000_075A);
        add_entry("ld_b_neg",  encode_2ri12(OPC_LD_B,   12'h009, 5'd0, 5'd20),
                  1, 0, 20, 32'hFFFF_FFF8);
        add_entry("ld_bu",     encode_2ri12(OPC_LD_BU,  12'h025, 5'd0, 5'd21),
                  1, 0, 21, 32'h0000_00A5);
        add_entry("ld_b_pos",  encode_2ri12(OPC_LD_B,   12'h013, 5'd0, 5'd22),
                  1, 0, 22, 32'h0000_0007);
        // r0 target shows on the port but stays zero
        add_entry("addi_r0",   encode_2ri12(OPC_ADDI_W, 12'h001, 5'd3, 5'd0), 1, 0, 0, 32'h800);
        add_entry("read_r0",   encode_2ri12(OPC_ADDI_W, 12'h000, 5'd0, 5'd5), 1, 0, 5, 32'h0);
        add_entry("preld",     encode_2ri12(OPC_PRELD,  12'h010, 5'd1, 5'd0), 0, 0, 0, 32'h0);
        add_entry("illegal",   encode_2ri12(10'h3FF,    12'h123, 5'd1, 5'd2), 0, 1, 0, 32'h0);
        // r2 untouched by the illegal word
        add_entry("after_ill", encode_2ri12(OPC_ORI,    12'h000, 5'd2, 5'd23),
                  1, 0, 23, 32'h0000_0FFF);
    endtask

    // One full four-phase exchange for table row idx
    task automatic run_entry(input int idx);
        int latency;
        int hold;
        latency = 0;
        hold    = idx % 4;           // Extra cycles with req held high
        @(posedge clk);
        #2;
        instr_i     = tbl_word[idx];
        instr_req_i = 1'b1;
        @(posedge clk);              // Accepting edge
        #2;
        while (instr_ack_o !== 1'b1) begin
            @(posedge clk);
            #2;
            latency++;
        end
        check_val(tbl_name[idx], "ack latency", 32'd3, latency);
        check_val(tbl_name[idx], "wb_valid", tbl_valid[idx], wb_valid_o);
        check_val(tbl_name[idx], "wb_illegal", tbl_illegal[idx], wb_illegal_o);
        check_val(tbl_name[idx], "wb_addr", tbl_addr[idx], wb_addr_o);
        check_val(tbl_name[idx], "wb_data", tbl_data[idx], wb_data_o);
        repeat (hold) begin
            @(posedge clk);
            #2;
            check_val(tbl_name[idx], "ack held", 32'd1, instr_ack_o);
            check_val(tbl_name[idx], "wb_data held", tbl_data[idx], wb_data_o);
        end
        instr_req_i = 1'b0;
        instr_i     = 32'h0;
        @(posedge clk);              // First edge with req low
        #2;
        check_val(tbl_name[idx], "ack release", 32'd0, instr_ack_o);
    endtask

    initial begin
        rst_n_i     = 1'b0;
        instr_req_i = 1'b0;
        instr_i     = 32'h0;
        build_table();
        repeat (2) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        check_val("reset", "ack", 32'd0, instr_ack_o);
        check_val("reset", "wb_valid", 32'd0, wb_valid_o);
        check_val("reset", "wb_illegal", 32'd0, wb_illegal_o);

        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
        end

        @(posedge clk);
        $display("Closing: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* compile.f */
la_core_pkg.sv
dec_exe_if.sv
exe_res_if.sv
decoder_2ri12.sv
gpr_file.sv
alu_lsu_exec.sv
result_commit.sv
la_2ri12_top.sv
tb_la_2ri12.sv

/* Bender.yml */
package:
  name: la_2ri12

sources:
  - la_core_pkg.sv
  - dec_exe_if.sv
  - exe_res_if.sv
  - decoder_2ri12.sv
  - gpr_file.sv
  - alu_lsu_exec.sv
  - result_commit.sv
  - la_2ri12_top.sv
  - target: simulation
    files:
      - tb_la_2ri12.sv
